/* rtl/ghash_pkg.sv */
package ghash_pkg;

    localparam int BLOCK_W    = 128;              // GHASH block
    localparam int WORD_W     = 32;               // APB data bus
    localparam int ADDR_W     = 8;                // APB address bus
    localparam int FIFO_DEPTH = 4;                // Buffered blocks
    localparam int FIFO_CNT_W = 3;                // Fill count, 0 to FIFO_DEPTH
    localparam int FIFO_PTR_W = 2;                // Slot index
    localparam int MUL_CNT_W  = 7;                // One step per operand bit

    typedef logic [BLOCK_W-1:0]    block_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [ADDR_W-1:0]     apb_addr_t;
    typedef logic [FIFO_CNT_W-1:0] fifo_cnt_t;
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [MUL_CNT_W-1:0]  mul_cnt_t;

    // GCM bit 0 sits in vector bit 127
    localparam block_t   GF_POLY_R = {8'hE1, 120'd0}; // R = 11100001 || 0^120
    localparam mul_cnt_t MUL_LAST  = 7'd127;           // Last multiply step

    localparam apb_addr_t REG_H0     = 8'h00;     // H, most significant word
    localparam apb_addr_t REG_H1     = 8'h04;
    localparam apb_addr_t REG_H2     = 8'h08;
    localparam apb_addr_t REG_H3     = 8'h0C;
    localparam apb_addr_t REG_D0     = 8'h10;     // Data block, most significant word
    localparam apb_addr_t REG_D1     = 8'h14;
    localparam apb_addr_t REG_D2     = 8'h18;
    localparam apb_addr_t REG_D3     = 8'h1C;     // Write pushes the block
    localparam apb_addr_t REG_CTRL   = 8'h20;
    localparam apb_addr_t REG_STATUS = 8'h24;
    localparam apb_addr_t REG_TAG0   = 8'h30;     // Hash, most significant word
    localparam apb_addr_t REG_TAG1   = 8'h34;
    localparam apb_addr_t REG_TAG2   = 8'h38;
    localparam apb_addr_t REG_TAG3   = 8'h3C;

    localparam int CTRL_CLEAR_BIT  = 0;           // Clears the hash state
    localparam int STAT_FULL_BIT   = 0;           // FIFO full
    localparam int STAT_BUSY_BIT   = 1;           // Core busy
    localparam int STAT_VALID_BIT  = 2;           // Result valid

    typedef enum logic [1:0]
    {
        CORE_IDLE,                                // Waiting for a block
        CORE_MUL,                                 // Bit-serial multiply
        CORE_DONE                                 // Write back product
    } core_state_t;

endpackage

/* rtl/ghash_apb_regs.sv */
`timescale 1ns/1ps

module ghash_apb_regs import ghash_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst,
    input  logic      i_psel,
    input  logic      i_penable,
    input  logic      i_pwrite,
    input  apb_addr_t i_paddr,
    input  word_t     i_pwdata,
    input  logic      i_full,
    input  logic      i_empty,
    input  logic      i_busy,
    input  block_t    i_hash,
    input  logic      i_hash_folded,
    output word_t     o_prdata,
    output logic      o_pready,
    output logic      o_pslverr,
    output logic      o_push,
    output block_t    o_push_block,
    output block_t    o_h_key,
    output logic      o_clear
);

    block_t h_key_q;                              // Hash subkey
    word_t  d0_q;                                 // Block words waiting for D3
    word_t  d1_q;
    word_t  d2_q;
    logic   clear_q;                              // Registered CTRL pulse
    logic   access;                               // Access phase
    logic   wr_acc;
    logic   rd_acc;
    logic   addr_ok;                              // Address is mapped
    logic   d3_wr;                                // Block-completing write
    word_t  status_w;

    assign access = i_psel && i_penable;
    assign wr_acc = access && i_pwrite;
    assign rd_acc = access && !i_pwrite;
    assign d3_wr  = wr_acc && (i_paddr == REG_D3);

    // Only D3 can stall, and only against a full FIFO
    assign o_pready  = !(d3_wr && i_full);
    assign o_pslverr = access && !addr_ok;        // Unmapped completes with error
    assign o_push    = d3_wr && !i_full;          // On completing cycle
    assign o_push_block = {d0_q, d1_q, d2_q, i_pwdata}; // D3 is least significant
    assign o_h_key   = h_key_q;
    assign o_clear   = clear_q;

    always_comb
    begin
        case (i_paddr)
            REG_H0, REG_H1, REG_H2, REG_H3,
            REG_D0, REG_D1, REG_D2, REG_D3,
            REG_CTRL, REG_STATUS,
            REG_TAG0, REG_TAG1, REG_TAG2, REG_TAG3:
                addr_ok = 1'b1;
            default:
                addr_ok = 1'b0;
        endcase
    end

    always_comb
    begin
        status_w                 = '0;
        status_w[STAT_FULL_BIT]  = i_full;
        status_w[STAT_BUSY_BIT]  = i_busy;
        // Nothing queued, nothing in flight, something folded
        status_w[STAT_VALID_BIT] = i_empty && !i_busy && i_hash_folded;
    end

    // Write path, payload registers
    always_ff @(posedge clk)
    begin
        if (wr_acc)
        begin
            case (i_paddr)
                REG_H0: h_key_q[127:96] <= i_pwdata;
                REG_H1: h_key_q[95:64]  <= i_pwdata;
                REG_H2: h_key_q[63:32]  <= i_pwdata;
                REG_H3: h_key_q[31:0]   <= i_pwdata;
                REG_D0: d0_q            <= i_pwdata;
                REG_D1: d1_q            <= i_pwdata;
                REG_D2: d2_q            <= i_pwdata;
                default: ;                        // D3 goes straight to the FIFO
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_rst)
            clear_q <= 1'b0;
        else
            clear_q <= wr_acc && (i_paddr == REG_CTRL) && i_pwdata[CTRL_CLEAR_BIT];
    end

    // Read mux, zero outside read access
    always_comb
    begin
        o_prdata = '0;
        if (rd_acc)
        begin
            case (i_paddr)
                REG_H0:     o_prdata = h_key_q[127:96];
                REG_H1:     o_prdata = h_key_q[95:64];
                REG_H2:     o_prdata = h_key_q[63:32];
                REG_H3:     o_prdata = h_key_q[31:0];
                REG_D0:     o_prdata = d0_q;
                REG_D1:     o_prdata = d1_q;
                REG_D2:     o_prdata = d2_q;
                REG_STATUS: o_prdata = status_w;
                REG_TAG0:   o_prdata = i_hash[127:96];
                REG_TAG1:   o_prdata = i_hash[95:64];
                REG_TAG2:   o_prdata = i_hash[63:32];
                REG_TAG3:   o_prdata = i_hash[31:0];
                default:    o_prdata = '0;        // D3, CTRL and unmapped
            endcase
        end
    end

endmodule

/* rtl/ghash_block_fifo.sv */
`timescale 1ns/1ps

module ghash_block_fifo import ghash_pkg::*;
(
    input  logic   clk,
    input  logic   i_rst,
    input  logic   i_push,
    input  block_t i_push_block,
    input  logic   i_pop,
    output block_t o_head_block,
    output logic   o_full,
    output logic   o_empty
);

    block_t    mem [FIFO_DEPTH];                  // Block storage
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;                             // Blocks held
    logic      do_push;
    logic      do_pop;

    assign do_push = i_push && !o_full;           // Overflow ignored
    assign do_pop  = i_pop && !o_empty;           // Underflow ignored

    always_ff @(posedge clk)
    begin
        if (i_rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;          // Wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= i_push_block;
    end

    assign o_head_block = mem[rd_ptr];            // Show-ahead head
    assign o_full       = (count == fifo_cnt_t'(FIFO_DEPTH));
    assign o_empty      = (count == '0);

endmodule

/* rtl/ghash_core.sv */
`timescale 1ns/1ps

module ghash_core import ghash_pkg::*;
(
    input  logic   clk,
    input  logic   i_rst,
    input  logic   i_clear,
    input  block_t i_h_key,
    input  logic   i_empty,
    input  block_t i_block,
    output logic   o_pop,
    output logic   o_busy,
    output block_t o_hash,
    output logic   o_hash_folded
);

    core_state_t state;
    logic        take_q;                          // Saw a block waiting
    mul_cnt_t    bit_cnt;                         // Multiply step
    block_t      x_sh;                            // Operand, next GCM bit at top
    block_t      v_acc;                           // H times x^i, reduced
    block_t      z_acc;                           // Partial product

    // Clear drops any fold in flight
    always_ff @(posedge clk)
    begin
        if (i_rst || i_clear)
        begin
            state         <= CORE_IDLE;
            take_q        <= 1'b0;
            bit_cnt       <= '0;
            o_hash        <= '0;
            o_hash_folded <= 1'b0;
        end
        else
        begin
            case (state)
                CORE_IDLE:
                begin
                    if (take_q)
                    begin
                        take_q  <= 1'b0;          // Pop is this cycle
                        bit_cnt <= '0;
                        state   <= CORE_MUL;
                    end
                    else
                        take_q <= !i_empty;       // Pop one cycle later
                end
                CORE_MUL:
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == MUL_LAST)
                        state <= CORE_DONE;       // 128 steps done
                end
                CORE_DONE:
                begin
                    o_hash        <= z_acc;       // New running hash
                    o_hash_folded <= 1'b1;
                    // Look ahead so back-to-back blocks cost 130 cycles
                    take_q        <= !i_empty;
                    state         <= CORE_IDLE;
                end
                default:
                    state <= CORE_IDLE;
            endcase
        end
    end

    // Multiplier datapath
    always_ff @(posedge clk)
    begin
        if (o_pop)
        begin
            x_sh  <= o_hash ^ i_block;            // Fold block into hash
            v_acc <= i_h_key;
            z_acc <= '0;
        end
        else if (state == CORE_MUL)
        begin
            if (x_sh[BLOCK_W-1])
                z_acc <= z_acc ^ v_acc;           // Add V for a set bit
            // Shift toward GCM bit 127, reduce on carry out
            if (v_acc[0])
                v_acc <= (v_acc >> 1) ^ GF_POLY_R;
            else
                v_acc <= v_acc >> 1;
            x_sh <= x_sh << 1;                    // Next operand bit
        end
    end

    assign o_pop  = take_q && (state == CORE_IDLE) && !i_clear;
    assign o_busy = (state != CORE_IDLE);

endmodule

/* rtl/ghash_top.sv */
`timescale 1ns/1ps

module ghash_top import ghash_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst,
    input  logic      i_psel,
    input  logic      i_penable,
    input  logic      i_pwrite,
    input  apb_addr_t i_paddr,
    input  word_t     i_pwdata,
    output word_t     o_prdata,
    output logic      o_pready,
    output logic      o_pslverr
);

    logic   push;                                 // Front end to FIFO
    block_t push_block;
    logic   full;
    logic   empty;                                // FIFO to core
    block_t head_block;
    logic   pop;
    logic   busy;                                 // Core to front end
    block_t hash;
    logic   hash_folded;
    block_t h_key;
    logic   clear;

    ghash_apb_regs u_regs
    (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_psel        (i_psel),
        .i_penable     (i_penable),
        .i_pwrite      (i_pwrite),
        .i_paddr       (i_paddr),
        .i_pwdata      (i_pwdata),
        .i_full        (full),
        .i_empty       (empty),
        .i_busy        (busy),
        .i_hash        (hash),
        .i_hash_folded (hash_folded),
        .o_prdata      (o_prdata),
        .o_pready      (o_pready),
        .o_pslverr     (o_pslverr),
        .o_push        (push),
        .o_push_block  (push_block),
        .o_h_key       (h_key),
        .o_clear       (clear)
    );

    ghash_block_fifo u_fifo
    (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_push       (push),
        .i_push_block (push_block),
        .i_pop        (pop),
        .o_head_block (head_block),
        .o_full       (full),
        .o_empty      (empty)
    );

    ghash_core u_core
    (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_clear       (clear),
        .i_h_key       (h_key),
        .i_empty       (empty),
        .i_block       (head_block),
        .o_pop         (pop),
        .o_busy        (busy),
        .o_hash        (hash),
        .o_hash_folded (hash_folded)
    );

endmodule

/* verif/ghash_asserts.sv */
`timescale 1ns/1ps

module ghash_asserts import ghash_pkg::*;
(
    input logic        clk,
    input logic        i_rst,
    input logic        i_psel,
    input logic        i_penable,
    input logic        i_pready,
    input logic        i_push,
    input logic        i_pop,
    input logic        i_empty,
    input logic        i_clear,
    input core_state_t i_state
);

    logic [7:0] mul_run;                          // Cycles in CORE_MUL so far
    logic [7:0] stall_run;                        // Wait states in a row
    fifo_cnt_t  occ;                              // Blocks held, counted from push and pop

    always_ff @(posedge clk)
    begin
        if (i_rst || i_clear)
            mul_run <= '0;
        else if (i_state == CORE_MUL)
            mul_run <= mul_run + 1'b1;
        else
            mul_run <= '0;
    end

    always_ff @(posedge clk)
    begin
        if (i_rst)
            stall_run <= '0;
        else if (!i_pready)
            stall_run <= stall_run + 1'b1;
        else
            stall_run <= '0;
    end

    always_ff @(posedge clk)
    begin
        if (i_rst)
            occ <= '0;
        else
        begin
            case ({i_push, i_pop})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;
            endcase
        end
    end

    a_pop_not_empty: assert property (@(posedge clk) disable iff (i_rst)
        i_pop |-> !i_empty)
        else $error("core popped an empty FIFO");

    a_push_not_full: assert property (@(posedge clk) disable iff (i_rst)
        i_push |-> (occ < fifo_cnt_t'(FIFO_DEPTH)))
        else $error("front end pushed into a full FIFO");

    // Wait states only inside an access phase, and a free slot within one block time
    a_pready_idle: assert property (@(posedge clk) disable iff (i_rst)
        !i_pready |-> (i_psel && i_penable && (stall_run < 8'd130)))
        else $error("pready low outside an access phase or for more than 130 cycles");

    a_mul_bound: assert property (@(posedge clk) disable iff (i_rst || i_clear)
        (i_state == CORE_MUL) |-> (mul_run < 8'd128))
        else $error("multiply ran past 128 cycles");

    a_mul_len: assert property (@(posedge clk) disable iff (i_rst || i_clear)
        (i_state == CORE_DONE) |-> (mul_run == 8'd128))
        else $error("multiply did not last 128 cycles");

endmodule

/* verif/tb_ghash.sv */
`timescale 1ns/1ps

module tb_ghash import ghash_pkg::*;
();

    localparam int NUM_ROWS   = 6;                // Row 0 published and last row overruns FIFO
    localparam int MAX_BLOCKS = 6;
    localparam int POLL_MAX   = 400;              // Status reads before giving up
    localparam int WD_CYCLES  = (NUM_ROWS + 1) * MAX_BLOCKS * 140 + (NUM_ROWS + 2) * 300 + 2000;
    localparam block_t R_POLY = {8'he1, 120'h0};  // x^128 folded back in GCM bit order

    logic      clk;
    logic      i_rst;
    logic      i_psel;
    logic      i_penable;
    logic      i_pwrite;
    apb_addr_t i_paddr;
    word_t     i_pwdata;
    word_t     o_prdata;
    logic      o_pready;
    logic      o_pslverr;

    block_t tbl_h   [NUM_ROWS];                   // Stimulus table
    int     tbl_n   [NUM_ROWS];
    block_t tbl_blk [NUM_ROWS][MAX_BLOCKS];
    block_t tbl_tag [NUM_ROWS];                   // Expected hash
    int     err_block;
    int     err_word;
    int     err_bit;
    int     err_other;
    int     stall_cycles;                         // APB wait states seen

    ghash_top uut
    (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr)
    );

    bind ghash_top ghash_asserts u_asserts
    (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pready  (o_pready),
        .i_push    (push),
        .i_pop     (pop),
        .i_empty   (empty),
        .i_clear   (clear),
        .i_state   (u_core.state)
    );

    always #4 clk = ~clk;                         // 8 ns period

    // GCM multiply with block bit 0 as the most significant vector bit
    function automatic block_t gf_mult(input block_t x, input block_t y);
        block_t z;
        block_t v;
        z = '0;
        v = y;
        for (int i = 0; i < BLOCK_W; i++)
        begin
            if (x[BLOCK_W-1-i])
                z = z ^ v;
            v = v[0] ? ((v >> 1) ^ R_POLY) : (v >> 1); // Times x with reduce on carry
        end
        return z;
    endfunction

    function automatic block_t ghash_model(input int r);
        block_t y;
        y = '0;
        for (int j = 0; j < tbl_n[r]; j++)
            y = gf_mult(y ^ tbl_blk[r][j], tbl_h[r]);
        return y;
    endfunction

    function automatic block_t rand_block();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    task automatic fill_table();
        tbl_h[0]      = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;
        tbl_n[0]      = 2;
        tbl_blk[0][0] = 128'h0388dace60b6a392f328c2b971b2fe78;
        tbl_blk[0][1] = 128'h80;                  // len(A) 0 and len(C) 128 bits
        tbl_tag[0]    = 128'hf38cbb1ad69223dcc3457ae5b6b0f885;
        for (int r = 1; r < NUM_ROWS; r++)
        begin
            tbl_h[r] = rand_block();
            tbl_n[r] = (r < NUM_ROWS - 1) ? r : MAX_BLOCKS;
            for (int j = 0; j < MAX_BLOCKS; j++)
                tbl_blk[r][j] = rand_block();
            tbl_tag[r] = ghash_model(r);
        end
    endtask

    task automatic check_block(input string what, input block_t got, input block_t exp);
        if (got !== exp)
        begin
            err_block++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input string what, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            err_word++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            err_bit++;
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // One APB transfer sampled at the falling edge
    task automatic apb_access(input logic wr, input apb_addr_t addr, input word_t wdata,
                              output word_t rdata, output logic err);
        @(posedge clk);
        i_psel    <= 1'b1;                        // Setup
        i_penable <= 1'b0;
        i_pwrite  <= wr;
        i_paddr   <= addr;
        i_pwdata  <= wdata;
        @(posedge clk);
        i_penable <= 1'b1;                        // Access
        @(negedge clk);
        while (!o_pready)
        begin
            stall_cycles++;
            @(negedge clk);
        end
        rdata = o_prdata;
        err   = o_pslverr;
        @(posedge clk);                           // Completing edge
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
    endtask

    task automatic reg_write(input apb_addr_t addr, input word_t data);
        word_t rd;
        logic  err;
        apb_access(1'b1, addr, data, rd, err);
        check_bit($sformatf("pslverr on write %h", addr), err, 1'b0);
    endtask

    task automatic reg_read(input apb_addr_t addr, output word_t data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        check_bit($sformatf("pslverr on read %h", addr), err, 1'b0);
    endtask

    task automatic read_tag(output block_t tag);
        word_t w0;
        word_t w1;
        word_t w2;
        word_t w3;
        reg_read(REG_TAG0, w0);
        reg_read(REG_TAG1, w1);
        reg_read(REG_TAG2, w2);
        reg_read(REG_TAG3, w3);
        tag = {w0, w1, w2, w3};
    endtask

    task automatic write_block(input block_t b);
        reg_write(REG_D0, b[127:96]);
        reg_write(REG_D1, b[95:64]);
        reg_write(REG_D2, b[63:32]);
        reg_write(REG_D3, b[31:0]);              // Push that may stall
    endtask

    task automatic wait_valid();
        word_t st;
        int    polls;
        st    = '0;
        polls = 0;
        while (!st[STAT_VALID_BIT] && polls < POLL_MAX)
        begin
            reg_read(REG_STATUS, st);
            polls++;
        end
        if (!st[STAT_VALID_BIT])
        begin
            err_other++;
            $display("result valid bit never rose after %0d status reads", polls);
        end
        else
            check_word("status when done", st, word_t'(1 << STAT_VALID_BIT));
    endtask

    task automatic run_row(input int r);
        block_t tag;
        word_t  st;
        reg_write(REG_CTRL, 32'h1);               // New message
        reg_read(REG_STATUS, st);
        check_word("status after clear", st, '0);
        reg_write(REG_H0, tbl_h[r][127:96]);
        reg_write(REG_H1, tbl_h[r][95:64]);
        reg_write(REG_H2, tbl_h[r][63:32]);
        reg_write(REG_H3, tbl_h[r][31:0]);
        for (int j = 0; j < tbl_n[r]; j++)
            write_block(tbl_blk[r][j]);
        wait_valid();
        read_tag(tag);
        check_block($sformatf("tag row %0d", r), tag, tbl_tag[r]);
    endtask

    initial
    begin
        block_t tag;
        word_t  rd;
        logic   err;
        clk          = 1'b0;
        err_block    = 0;
        err_word     = 0;
        err_bit      = 0;
        err_other    = 0;
        stall_cycles = 0;
        i_rst     <= 1'b1;
        i_psel    <= 1'b0;
        i_penable <= 1'b0;
        i_pwrite  <= 1'b0;
        i_paddr   <= '0;
        i_pwdata  <= '0;
        void'($urandom(16176));
        fill_table();
        repeat (10) @(posedge clk);
        i_rst <= 1'b0;

        reg_read(REG_STATUS, rd);
        check_word("status after reset", rd, '0);
        read_tag(tag);
        check_block("tag after reset", tag, '0);
        check_block("model on published vector", ghash_model(0), tbl_tag[0]);

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            stall_cycles = 0;
            run_row(r);
            if (tbl_n[r] > FIFO_DEPTH + 1 && stall_cycles == 0)
            begin
                err_other++;
                $display("no APB wait states seen while writing %0d blocks", tbl_n[r]);
            end
        end

        // Unmapped space errors out and leaves state alone
        apb_access(1'b1, 8'h40, 32'hdeadbeef, rd, err);
        check_bit("pslverr unmapped write", err, 1'b1);
        apb_access(1'b0, 8'h28, '0, rd, err);
        check_bit("pslverr unmapped read", err, 1'b1);
        reg_read(REG_H0, rd);
        check_word("H0 after unmapped", rd, tbl_h[NUM_ROWS-1][127:96]);
        read_tag(tag);
        check_block("tag after unmapped", tag, tbl_tag[NUM_ROWS-1]);

        run_row(0);                               // Published vector after another message

        $display("errors: tag %0d, word %0d, pslverr %0d, other %0d",
                 err_block, err_word, err_bit, err_other);
        if (err_block + err_word + err_bit + err_other == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    initial
    begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run stalled", WD_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* build.f */
rtl/ghash_pkg.sv
rtl/ghash_apb_regs.sv
rtl/ghash_block_fifo.sv
rtl/ghash_core.sv
rtl/ghash_top.sv
verif/ghash_asserts.sv
verif/tb_ghash.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_ghash
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "TB PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
